// File: rtl/ntt_pkg.sv
// NTT processing element package with opcode encoding and default operand width
`default_nettype none

package ntt_pkg;

    // ==================================================================
    // Datapath sizing
    // ==================================================================

    // Default operand width for the whole processing element
    // Top level passes its own REG_SIZE down, this is only the default
    localparam int NTT_REG_SIZE_DEFAULT = 32;

    // ==================================================================
    // Opcodes
    // ==================================================================

    // Operation select for the butterfly stage
    // OP_ADD  lane 0 gives opa + opb mod prime
    // OP_SUB  lane 0 gives opa - opb mod prime
    // OP_BFLY lane 0 gives the sum, lane 1 the difference
    // Encoding 2'b11 is unused
    typedef enum logic [1:0] {
        OP_ADD  = 2'b00,
        OP_SUB  = 2'b01,
        OP_BFLY = 2'b10
    } ntt_op_e;

endpackage : ntt_pkg

`default_nettype wire

// File: rtl/mod_op_if.sv
// Modular add/sub request and result bundle between butterfly and one lane
`timescale 1ns/1ns
`default_nettype none

interface mod_op_if #(
    parameter int REG_SIZE = ntt_pkg::NTT_REG_SIZE_DEFAULT
);

    // Request side
    // One-cycle start strobe, restarts the lane pipeline
    logic                add_en;
    // High selects subtraction, low selects addition
    logic                sub;
    // Operands, both expected below the prime
    logic [REG_SIZE-1:0] opa;
    logic [REG_SIZE-1:0] opb;

    // Result side
    // Result holds until the next start or zeroize
    logic [REG_SIZE-1:0] res;
    // One-cycle pulse, two edges after add_en was sampled
    logic                ready;

    // Butterfly drives requests and observes results
    modport requester (
        output add_en, sub, opa, opb,
        input  res, ready
    );

    // Lane consumes requests and returns results
    modport lane (
        input  add_en, sub, opa, opb,
        output res, ready
    );

endinterface : mod_op_if

`default_nettype wire

// File: rtl/ntt_adder.sv
// Full-width binary adder with carry in and carry out for the modular lanes
`timescale 1ns/1ns
`default_nettype none

module ntt_adder #(
    parameter int RADIX = ntt_pkg::NTT_REG_SIZE_DEFAULT
) (
    input  logic [RADIX-1:0] a_i,
    input  logic [RADIX-1:0] b_i,
    input  logic             cin_i,
    output logic [RADIX-1:0] s_o,
    output logic             cout_o
);

    // One bit wider than the operands to catch the carry out
    logic [RADIX:0] sum_ext;

    // Zero-extend everything so the carry lands in the top bit
    // Carry in of one with an inverted operand gives two's complement subtraction
    assign sum_ext = {1'b0, a_i}
                   + {1'b0, b_i}
                   + {{RADIX{1'b0}}, cin_i};

    // Lower bits are the wrapped sum
    assign s_o    = sum_ext[RADIX-1:0];

    // Carry out drives the modular correction choice in the lane
    // For subtraction it is high when no borrow occurred
    assign cout_o = sum_ext[RADIX];

endmodule : ntt_adder

`default_nettype wire

// File: rtl/ntt_add_sub_mod.sv
// Two-stage modular add/subtract lane computing opa +/- opb mod prime
`timescale 1ns/1ns
`default_nettype none

module ntt_add_sub_mod #(
    parameter int REG_SIZE = ntt_pkg::NTT_REG_SIZE_DEFAULT
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    mod_op_if.lane              op,
    input  logic [REG_SIZE-1:0] prime_i
);

    // ==================================================================
    // Stage one, raw sum or difference
    // ==================================================================

    // Second operand, inverted for subtraction
    logic [REG_SIZE-1:0] opb_s1;
    logic [REG_SIZE-1:0] sum_s1;
    logic                carry_s1;

    // Registered stage one state
    logic [REG_SIZE-1:0] sum_q;
    logic                carry_q;
    // High for addition, the inverted subtract flag
    logic                add_q;
    // Correction operand, prime for sub and inverted prime for add
    logic [REG_SIZE-1:0] corr_q;

    // Stage two, corrected value
    logic [REG_SIZE-1:0] sum_s2;
    logic                carry_s2;

    // Ready shift register, loaded with 2'b10 on start
    logic [1:0]          ready_sr;

    assign opb_s1 = op.sub ? ~op.opb : op.opb;

    // opa + opb, or opa + ~opb + 1
    ntt_adder #(
        .RADIX (REG_SIZE)
    ) u_adder_s1 (
        .a_i    (op.opa),
        .b_i    (opb_s1),
        .cin_i  (op.sub),
        .s_o    (sum_s1),
        .cout_o (carry_s1)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_q   <= '0;
            carry_q <= 1'b0;
            add_q   <= 1'b0;
            corr_q  <= '0;
        end else if (zeroize_i) begin
            sum_q   <= '0;
            carry_q <= 1'b0;
            add_q   <= 1'b0;
            corr_q  <= '0;
        end else if (op.add_en) begin
            sum_q   <= sum_s1;
            carry_q <= carry_s1;
            add_q   <= ~op.sub;
            corr_q  <= op.sub ? prime_i : ~prime_i;
        end
    end

    // ==================================================================
    // Stage two, correction and result select
    // ==================================================================

    // Add: sum - prime via ~prime + 1; sub: sum + prime with no carry in
    ntt_adder #(
        .RADIX (REG_SIZE)
    ) u_adder_s2 (
        .a_i    (sum_q),
        .b_i    (corr_q),
        .cin_i  (add_q),
        .s_o    (sum_s2),
        .cout_o (carry_s2)
    );

    // Addition subtracts the prime when the true sum reached it
    // True sum >= prime exactly when one of the two carries is set
    // Subtraction adds the prime back only after a borrow
    assign op.res = add_q ? ((carry_q ^ carry_s2) ? sum_s2 : sum_q)
                          : (carry_q ? sum_q : sum_s2);

    // Ready pulse one edge after the stage one registers load
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ready_sr <= 2'b00;
        end else if (zeroize_i) begin
            ready_sr <= 2'b00;
        end else if (op.add_en) begin
            ready_sr <= 2'b10;
        end else begin
            ready_sr <= ready_sr >> 1;
        end
    end

    assign op.ready = ready_sr[0];

endmodule : ntt_add_sub_mod

`default_nettype wire

// File: rtl/ntt_butterfly.sv
// Butterfly stage decoding the opcode into two modular add/sub lanes
`timescale 1ns/1ns
`default_nettype none

module ntt_butterfly #(
    parameter int REG_SIZE = ntt_pkg::NTT_REG_SIZE_DEFAULT
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic                start_i,
    input  ntt_pkg::ntt_op_e    op_i,
    input  logic [REG_SIZE-1:0] opa_i,
    input  logic [REG_SIZE-1:0] opb_i,
    input  logic [REG_SIZE-1:0] prime_i,
    output logic [REG_SIZE-1:0] res_a_o,
    output logic [REG_SIZE-1:0] res_b_o,
    output logic                ready_o,
    output logic                bfly_o
);

    import ntt_pkg::*;

    // Lane 0 carries the sum or the single op, lane 1 the difference
    mod_op_if #(.REG_SIZE(REG_SIZE)) lane0_if ();
    mod_op_if #(.REG_SIZE(REG_SIZE)) lane1_if ();

    // Set at start when the op is a butterfly
    logic bfly_q;

    // ==================================================================
    // Opcode decode
    // ==================================================================

    // Every start runs lane 0, only a butterfly runs lane 1
    always_comb begin
        lane0_if.add_en = start_i;
        lane1_if.add_en = 1'b0;
        lane0_if.sub    = 1'b0;
        case (op_i)
            OP_SUB: begin
                lane0_if.sub = 1'b1;
            end
            OP_BFLY: begin
                lane1_if.add_en = start_i;
            end
            default: begin
                // OP_ADD and the unused code run lane 0 as an add
                lane0_if.sub = 1'b0;
            end
        endcase
    end

    // Lane 1 only ever subtracts
    assign lane1_if.sub = 1'b1;

    // Both lanes see the operands unchanged
    assign lane0_if.opa = opa_i;
    assign lane0_if.opb = opb_i;
    assign lane1_if.opa = opa_i;
    assign lane1_if.opb = opb_i;

    // ==================================================================
    // Lanes and result merge
    // ==================================================================

    ntt_add_sub_mod #(
        .REG_SIZE (REG_SIZE)
    ) u_lane0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .op        (lane0_if.lane),
        .prime_i   (prime_i)
    );

    ntt_add_sub_mod #(
        .REG_SIZE (REG_SIZE)
    ) u_lane1 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .op        (lane1_if.lane),
        .prime_i   (prime_i)
    );

    // Butterfly flag, reloaded on every start so a restart updates it
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bfly_q <= 1'b0;
        end else if (zeroize_i) begin
            bfly_q <= 1'b0;
        end else if (start_i) begin
            bfly_q <= (op_i == OP_BFLY);
        end
    end

    assign res_a_o = lane0_if.res;
    assign res_b_o = lane1_if.res;

    // Lane 0 runs on every op, so its pulse is the stage ready
    assign ready_o = lane0_if.ready;
    // On a butterfly lane 1 started on the same edge and pulses in step
    assign bfly_o  = lane0_if.ready & lane1_if.ready & bfly_q;

endmodule : ntt_butterfly

`default_nettype wire

// File: rtl/ntt_pe_top.sv
// NTT add/sub processing element top level with plain ports around the butterfly
`timescale 1ns/1ns
`default_nettype none

module ntt_pe_top #(
    parameter int REG_SIZE = ntt_pkg::NTT_REG_SIZE_DEFAULT
) (
    // Clock and reset
    input  logic                clk,
    input  logic                reset_n,
    // Synchronous clear of both lanes and the butterfly flag
    input  logic                zeroize_i,

    // Request, start is a one-cycle strobe with no back-pressure
    input  logic                start_i,
    input  ntt_pkg::ntt_op_e    op_i,
    input  logic [REG_SIZE-1:0] opa_i,
    input  logic [REG_SIZE-1:0] opb_i,
    // Modulus shared by both lanes
    input  logic [REG_SIZE-1:0] prime_i,

    // Results, valid from the ready pulse until the next start
    output logic [REG_SIZE-1:0] res_a_o,
    output logic [REG_SIZE-1:0] res_b_o,
    // Ready two edges after start, bfly marks a butterfly result
    output logic                ready_o,
    output logic                bfly_o
);

    // ==================================================================
    // Butterfly stage
    // ==================================================================

    // Width set here and passed down to both lanes and their adders
    ntt_butterfly #(
        .REG_SIZE (REG_SIZE)
    ) u_butterfly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .start_i   (start_i),
        .op_i      (op_i),
        .opa_i     (opa_i),
        .opb_i     (opb_i),
        .prime_i   (prime_i),
        .res_a_o   (res_a_o),
        .res_b_o   (res_b_o),
        .ready_o   (ready_o),
        .bfly_o    (bfly_o)
    );

endmodule : ntt_pe_top

`default_nettype wire

// File: sim/ntt_pe_properties.sv
// Bound timing and control assertions for the NTT processing element top level
`timescale 1ns/1ns
`default_nettype none

module ntt_pe_properties #(
    parameter int REG_SIZE = ntt_pkg::NTT_REG_SIZE_DEFAULT
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic                start_i,
    input  logic [REG_SIZE-1:0] res_a_o,
    input  logic [REG_SIZE-1:0] res_b_o,
    input  logic                ready_o,
    input  logic                bfly_o
);

    // Count of failed assertions for the closing summary
    int   prop_fail_count = 0;
    // Set by the first start after reset
    logic started_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            started_q <= 1'b0;
        end else if (start_i) begin
            started_q <= 1'b1;
        end
    end

    // ==================================================================
    // Latency
    // ==================================================================

    // Start with a quiet following edge gives ready two edges later
    a_start_to_ready: assert property (@(posedge clk) disable iff (!reset_n)
        $past(start_i && !zeroize_i) && !start_i && !zeroize_i |=> ready_o)
        else begin
            prop_fail_count++;
            $error("ready_o missing two edges after start_i");
        end

    a_ready_single: assert property (@(posedge clk) disable iff (!reset_n)
        ready_o |=> !ready_o)
        else begin
            prop_fail_count++;
            $error("ready_o high for two cycles in a row");
        end

    a_ready_needs_start: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(ready_o) |-> $past(start_i, 2))
        else begin
            prop_fail_count++;
            $error("ready_o rose without start_i two edges earlier");
        end

    // ==================================================================
    // Reset and zeroize
    // ==================================================================

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!reset_n)
        !started_q |-> !ready_o && !bfly_o)
        else begin
            prop_fail_count++;
            $error("ready_o or bfly_o high before the first start");
        end

    // Zeroize right after a start drops the pending result
    a_zeroize_drops_ready: assert property (@(posedge clk) disable iff (!reset_n)
        $past(start_i) && zeroize_i |=> !ready_o)
        else begin
            prop_fail_count++;
            $error("ready_o pulsed after a zeroize");
        end

    a_zeroize_clears: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> res_a_o == '0 && res_b_o == '0)
        else begin
            prop_fail_count++;
            $error("results not cleared by zeroize");
        end

endmodule : ntt_pe_properties

bind ntt_pe_top ntt_pe_properties #(
    .REG_SIZE (REG_SIZE)
) u_properties (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize_i (zeroize_i),
    .start_i   (start_i),
    .res_a_o   (res_a_o),
    .res_b_o   (res_b_o),
    .ready_o   (ready_o),
    .bfly_o    (bfly_o)
);

`default_nettype wire

// File: sim/ntt_pe_tb.sv
// Testbench for the NTT add/sub processing element with LFSR stimulus and a reference model
`timescale 1ns/1ns
`default_nettype none

module ntt_pe_tb;

    import ntt_pkg::*;

    localparam int REG_SIZE     = 32;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 40;
    localparam int READY_LIMIT  = 4;
    // Random and edge-case ops per prime, plus the zeroize and restart runs
    localparam int NUM_TESTS    = 2 * (3 * NUM_RANDOM + 5) + 4;
    localparam int TIMEOUT_NS   = (NUM_TESTS * 3 + RESET_CYCLES + 100) * CLK_PERIOD;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic                clk = 1'b0;
    logic                reset_n;
    logic                zeroize;
    logic                start;
    ntt_op_e             op;
    logic [REG_SIZE-1:0] opa;
    logic [REG_SIZE-1:0] opb;
    logic [REG_SIZE-1:0] prime;
    logic [REG_SIZE-1:0] res_a;
    logic [REG_SIZE-1:0] res_b;
    logic                ready;
    logic                bfly;

    // Reference model state, captured at each start
    ntt_op_e             model_op;
    logic [REG_SIZE-1:0] model_a;
    logic [REG_SIZE-1:0] model_b;
    logic [31:0]         lfsr_q;
    int                  value_errors;
    int                  timing_errors;
    int                  prop_errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    ntt_pe_top #(
        .REG_SIZE (REG_SIZE)
    ) u_ntt_pe_top (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize),
        .start_i   (start),
        .op_i      (op),
        .opa_i     (opa),
        .opb_i     (opb),
        .prime_i   (prime),
        .res_a_o   (res_a),
        .res_b_o   (res_b),
        .ready_o   (ready),
        .bfly_o    (bfly)
    );

    // ==================================================================
    // Stimulus and reference model
    // ==================================================================

    // Galois step, shift right and fold the taps in when the LSB was set
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // Operand below the prime, one LFSR step per bit, redrawn when too large
    task automatic draw_operand(output logic [REG_SIZE-1:0] v);
        int nbits;
        nbits = $clog2(prime);
        v = prime;
        while (v >= prime) begin
            v = '0;
            for (int i = 0; i < nbits; i++) begin
                v = {v[REG_SIZE-2:0], lfsr_q[0]};
                lfsr_q = lfsr_next(lfsr_q);
            end
        end
    endtask

    // Reduced sum or difference, operands already below the prime
    function automatic logic [REG_SIZE-1:0] mod_ref(input logic [REG_SIZE-1:0] a,
                                                    input logic [REG_SIZE-1:0] b,
                                                    input logic is_sub);
        logic [REG_SIZE:0] sum;
        if (is_sub) begin
            return (a >= b) ? a - b : a + (prime - b);
        end
        sum = {1'b0, a} + {1'b0, b};
        return (sum >= {1'b0, prime}) ? sum[REG_SIZE-1:0] - prime : sum[REG_SIZE-1:0];
    endfunction

    task automatic report_value(input string name, input logic [REG_SIZE-1:0] exp_v,
                                input logic [REG_SIZE-1:0] act_v);
        $display("CHECK FAILED %s expected %h actual %h", name, exp_v, act_v);
        value_errors++;
    endtask

    task automatic drive_start(input ntt_op_e o, input logic [REG_SIZE-1:0] a,
                               input logic [REG_SIZE-1:0] b);
        @(posedge clk);
        #1;
        start    = 1'b1;
        op       = o;
        opa      = a;
        opb      = b;
        model_op = o;
        model_a  = a;
        model_b  = b;
    endtask

    // Drop start, wait for the ready pulse and compare against the model
    task automatic finish_op();
        int                  cycles;
        logic                exp_bfly;
        logic [REG_SIZE-1:0] exp_a;
        logic [REG_SIZE-1:0] exp_b;
        @(posedge clk);
        #1;
        start  = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ready && cycles < READY_LIMIT);
        if (!ready) begin
            $display("Timeout waiting for ready_o after a start");
            timing_errors++;
        end else begin
            exp_a    = mod_ref(model_a, model_b, model_op == OP_SUB);
            exp_b    = mod_ref(model_a, model_b, 1'b1);
            exp_bfly = (model_op == OP_BFLY);
            assert (res_a == exp_a) else report_value("res_a_o", exp_a, res_a);
            assert (bfly == exp_bfly)
                else report_value("bfly_o", REG_SIZE'(exp_bfly), REG_SIZE'(bfly));
            if (exp_bfly) begin
                assert (res_b == exp_b) else report_value("res_b_o", exp_b, res_b);
            end
        end
    endtask

    task automatic run_op(input ntt_op_e o, input logic [REG_SIZE-1:0] a,
                          input logic [REG_SIZE-1:0] b);
        drive_start(o, a, b);
        finish_op();
    endtask

    task automatic run_prime(input logic [REG_SIZE-1:0] p);
        logic [REG_SIZE-1:0] a;
        logic [REG_SIZE-1:0] b;
        @(posedge clk);
        #1;
        prime = p;
        // Edge cases at zero and prime - 1, with the subtract wrap
        run_op(OP_ADD, '0, '0);
        run_op(OP_ADD, p - 32'd1, p - 32'd1);
        run_op(OP_SUB, '0, p - 32'd1);
        run_op(OP_SUB, p - 32'd1, '0);
        run_op(OP_BFLY, 32'd1, p - 32'd1);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            draw_operand(a);
            draw_operand(b);
            run_op(OP_ADD, a, b);
            draw_operand(a);
            draw_operand(b);
            run_op(OP_SUB, a, b);
            draw_operand(a);
            draw_operand(b);
            run_op(OP_BFLY, a, b);
        end
    endtask

    // Zeroize the cycle after a start, results must read zero
    task automatic check_zeroize();
        drive_start(OP_BFLY, 32'd5, 32'd3);
        @(posedge clk);
        #1;
        start   = 1'b0;
        zeroize = 1'b1;
        @(posedge clk);
        #1;
        zeroize = 1'b0;
        @(negedge clk);
        assert (res_a == '0) else report_value("res_a_o", '0, res_a);
        assert (res_b == '0) else report_value("res_b_o", '0, res_b);
        assert (!ready) else report_value("ready_o", '0, REG_SIZE'(ready));
    endtask

    // Back-to-back starts, only the second result is announced
    task automatic check_restart();
        logic [REG_SIZE-1:0] a;
        logic [REG_SIZE-1:0] b;
        draw_operand(a);
        draw_operand(b);
        drive_start(OP_SUB, a, b);
        draw_operand(a);
        draw_operand(b);
        drive_start(OP_BFLY, a, b);
        finish_op();
    endtask

    // ==================================================================
    // Main sequence and watchdog
    // ==================================================================

    initial begin
        reset_n       = 1'b0;
        zeroize       = 1'b0;
        start         = 1'b0;
        op            = OP_ADD;
        opa           = '0;
        opb           = '0;
        prime         = 32'hFFFFF001;
        lfsr_q        = 32'h9c6cac6a;
        value_errors  = 0;
        timing_errors = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;
        run_prime(32'hFFFFF001);
        check_zeroize();
        check_restart();
        run_prime(32'd17);
        check_restart();
        // Let the last concurrent assertions evaluate
        repeat (3) @(posedge clk);
        prop_errors = u_ntt_pe_top.u_properties.prop_fail_count;
        $display("Errors: value %0d, timing %0d, property %0d",
                 value_errors, timing_errors, prop_errors);
        if (value_errors + timing_errors + prop_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the run did not complete", TIMEOUT_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule : ntt_pe_tb

`default_nettype wire

// File: ntt_pe.f
rtl/ntt_pkg.sv
rtl/mod_op_if.sv
rtl/ntt_adder.sv
rtl/ntt_add_sub_mod.sv
rtl/ntt_butterfly.sv
rtl/ntt_pe_top.sv
sim/ntt_pe_properties.sv
sim/ntt_pe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the NTT processing element testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
    --top-module ntt_pe_tb -f ntt_pe.f -o ntt_pe_sim \
    && ./obj_dir/ntt_pe_sim +verilator+error+limit+1000 | tee "$LOG" \
    || { echo "Build or simulation run failed"; exit 1; }
grep -qx "Result: PASSED" "$LOG" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
